// ==== build.f ====
+incdir+rtl
rtl/chip8_pkg.sv
rtl/chip8_alu.sv
rtl/chip8_reg_file.sv
rtl/chip8_pc_stack.sv
rtl/chip8_sequencer.sv
rtl/chip8_decoder.sv
rtl/chip8_core.sv
verification/chip8_core_assertions.sv
verification/chip8_core_tb.sv

// ==== Makefile ====
# Verilator flow for the CHIP-8 core testbench

VERILATOR ?= verilator
TOP       ?= chip8_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/chip8_core_tb.sv ====
// CHIP-8 core testbench driving random instruction streams against a reference model
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_core_tb;

	localparam int TIMEOUT_CYCLES = 20;
	localparam logic [3:0] SKIP_OPS [4] = '{4'h3, 4'h4, 4'h5, 4'h9};
	localparam logic [3:0] ALU_SUBS [9] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE};

	logic                     cpu_clk;
	logic                     rst;
	logic                     instr_valid;
	logic [15:0]              instruction;
	logic                     ready;
	logic [`CHIP8_ADDR_W-1:0] pc;
	logic [15:0]              i_reg;
	logic [3:0]               dbg_reg_addr;
	logic [7:0]               dbg_reg_data;

	// Reference state
	logic [7:0]  v_model [16];
	logic [15:0] i_model;
	logic [11:0] pc_model;
	logic [11:0] ret_stack [$];

	logic [31:0] lcg_state;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;

	chip8_core u_chip8_core (.*);

	always #50 cpu_clk = ~cpu_clk;

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// Upper half has the longer period
		return lcg_state[31:16];
	endfunction

	// 8xyk rules with VF written after Vx so the flag wins when x is F
	task automatic model_alu(input logic [3:0] x, input logic [3:0] n,
			input logic [7:0] vx, input logic [7:0] vy);
		logic [7:0] res;
		logic       flag;
		logic       write;
		res   = vx;
		flag  = 1'b0;
		write = 1'b1;
		case (n)
			4'h0: res = vy;
			4'h1: res = vx | vy;
			4'h2: res = vx & vy;
			4'h3: res = vx ^ vy;
			4'h4: {flag, res} = {1'b0, vx} + {1'b0, vy};
			4'h5: begin
				res  = vx - vy;
				flag = (vx >= vy);
			end
			4'h6: begin
				res  = {1'b0, vx[7:1]};
				flag = vx[0];
			end
			4'h7: begin
				res  = vy - vx;
				flag = (vy >= vx);
			end
			4'hE: begin
				res  = {vx[6:0], 1'b0};
				flag = vx[7];
			end
			default: write = 1'b0;
		endcase
		if (write) v_model[x] = res;
		// Only arithmetic and shifts touch VF
		if (n inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE}) v_model[15] = {7'h00, flag};
	endtask

	task automatic model_step(input logic [15:0] w);
		logic [3:0]  x;
		logic [7:0]  kk;
		logic [7:0]  vx;
		logic [7:0]  vy;
		logic [11:0] nnn;
		logic [11:0] next_pc;
		x       = w[11:8];
		kk      = w[7:0];
		nnn     = w[11:0];
		vx      = v_model[x];
		vy      = v_model[w[7:4]];
		next_pc = pc_model + 12'd2;
		case (w[15:12])
			4'h0: if (w == 16'h00EE) next_pc = ret_stack.pop_back();
			4'h1: next_pc = nnn;
			4'h2: begin
				// Return lands on the word after the CALL
				ret_stack.push_back(pc_model + 12'd2);
				next_pc = nnn;
			end
			4'h3: if (vx == kk) next_pc = pc_model + 12'd4;
			4'h4: if (vx != kk) next_pc = pc_model + 12'd4;
			4'h5: if (w[3:0] == 4'h0 && vx == vy) next_pc = pc_model + 12'd4;
			4'h9: if (w[3:0] == 4'h0 && vx != vy) next_pc = pc_model + 12'd4;
			4'h6: v_model[x] = kk;
			4'h7: v_model[x] = vx + kk;
			4'h8: model_alu(x, w[3:0], vx, vy);
			4'hA: i_model = {4'h0, nnn};
			4'hB: next_pc = nnn + {4'h0, v_model[0]};
			4'hF: if (kk == 8'h1E) i_model = i_model + {8'h00, vx};
			default: ;
		endcase
		pc_model = next_pc;
	endtask

	// Send one instruction through the strobe and wait for ready to return
	task automatic run_instr(input logic [15:0] w);
		int waited;
		if (timed_out) return;
		waited = 0;
		while (!ready && waited < TIMEOUT_CYCLES) begin
			@(negedge cpu_clk);
			waited++;
		end
		if (!ready) begin
			$display("Core never became ready for %h at %0t", w, $time);
			timed_out = 1'b1;
			errors++;
			return;
		end
		@(posedge cpu_clk);
		instr_valid <= 1'b1;
		instruction <= w;
		@(posedge cpu_clk);
		instr_valid <= 1'b0;
		model_step(w);
		waited = 0;
		do begin
			@(negedge cpu_clk);
			waited++;
		end while (!ready && waited < TIMEOUT_CYCLES);
		if (!ready) begin
			$display("Core did not return ready after %h at %0t", w, $time);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic read_reg(input logic [3:0] r, output logic [7:0] d);
		@(posedge cpu_clk);
		dbg_reg_addr <= r;
		@(negedge cpu_clk);
		d = dbg_reg_data;
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// PC, I, the target register and VF
	task automatic check_state(input logic [3:0] x);
		logic [7:0] d;
		check_value("PC", {4'h0, pc}, {4'h0, pc_model});
		check_value("I", i_reg, i_model);
		read_reg(x, d);
		check_value($sformatf("V%h", x), {8'h00, d}, {8'h00, v_model[x]});
		read_reg(4'hF, d);
		check_value("VF", {8'h00, d}, {8'h00, v_model[15]});
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin
		logic [15:0] r;
		logic [3:0]  x;
		logic [3:0]  y;
		logic [7:0]  kk;
		logic [7:0]  d;
		cpu_clk      = 1'b0;
		rst          = 1'b1;
		instr_valid  = 1'b0;
		instruction  = 16'h0000;
		dbg_reg_addr = 4'h0;
		lcg_state    = 32'he509_6ea9;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		i_model      = 16'h0000;
		pc_model     = 12'h200;
		for (int k = 0; k < 16; k++) v_model[k] = 8'h00;
		repeat (2) @(posedge cpu_clk);
		rst <= 1'b0;
		@(negedge cpu_clk);

		// Reset state with every register read through the debug port
		check_value("ready", {15'h0000, ready}, 16'h0001);
		check_value("PC", {4'h0, pc}, 16'h0200);
		check_value("I", i_reg, 16'h0000);
		for (int k = 0; k < 16; k++) begin
			read_reg(k[3:0], d);
			check_value("reset register", {8'h00, d}, 16'h0000);
		end
		end_test("reset");

		// 6xkk and 7xkk
		for (int k = 0; k < 24; k++) begin
			r = next_rand();
			run_instr({r[15] ? 4'h7 : 4'h6, r[11:0]});
			check_state(r[11:8]);
		end
		end_test("immediate loads");

		// Fresh values in every register before all nine 8xyk forms
		for (int k = 0; k < 16; k++) begin
			r = next_rand();
			run_instr({4'h6, k[3:0], r[7:0]});
		end
		for (int k = 0; k < 36; k++) begin
			r = next_rand();
			run_instr({4'h8, r[11:8], r[7:4], ALU_SUBS[r % 16'd9]});
			check_state(r[11:8]);
		end
		end_test("register ALU");

		// Half the skips forced equal
		for (int k = 0; k < 32; k++) begin
			r = next_rand();
			x = r[7:4];
			if (r[8]) begin
				kk = v_model[x];
				y  = x;
			end else begin
				kk = v_model[x] ^ 8'h5A;
				y  = (r[15:12] == x) ? x + 4'h1 : r[15:12];
			end
			if (SKIP_OPS[r[1:0]] inside {4'h3, 4'h4}) run_instr({SKIP_OPS[r[1:0]], x, kk});
			else run_instr({SKIP_OPS[r[1:0]], x, y, 4'h0});
			check_state(x);
		end
		end_test("skips");

		// Even targets only so JP V0 lands on an even address with an even V0
		for (int k = 0; k < 6; k++) begin
			r = next_rand();
			run_instr({4'h1, r[11:1], 1'b0});
			check_state(4'h0);
			r = next_rand();
			run_instr({4'h6, 4'h0, r[7:1], 1'b0});
			r = next_rand();
			run_instr({4'hB, r[11:1], 1'b0});
			check_state(4'h0);
			for (int c = 0; c < 3; c++) begin
				r = next_rand();
				run_instr({4'h2, r[11:1], 1'b0});
				check_state(4'h0);
			end
			for (int c = 0; c < 3; c++) begin
				run_instr(16'h00EE);
				check_state(4'h0);
			end
		end
		end_test("control flow");

		// Annn and a dropped opcode as a no-op before several Fx1E
		for (int k = 0; k < 12; k++) begin
			r = next_rand();
			run_instr({4'hA, r[11:0]});
			check_state(4'h0);
			r = next_rand();
			run_instr({4'hC, r[11:0]});
			check_state(r[11:8]);
			for (int j = 0; j < 3; j++) begin
				r = next_rand();
				run_instr({4'hF, r[3:0], 8'h1E});
				check_state(r[3:0]);
			end
		end
		end_test("index register");

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verification/chip8_core_assertions.sv ====
// CHIP-8 core protocol checks: ready window, PC update point and PC alignment
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_core_assertions (
	input logic                     cpu_clk,
	input logic                     rst,
	input logic                     instr_valid,
	input logic                     ready,
	input logic [1:0]               stage,
	input logic [`CHIP8_ADDR_W-1:0] pc
);

	// Accepted word holds ready low for exactly two cycles
	assert property (@(posedge cpu_clk) disable iff (rst)
		(instr_valid && ready) |=> !ready ##1 !ready ##1 ready)
		else $error("ready window after acceptance is not two cycles");

	// PC moves only on the edge that leaves stage 2
	assert property (@(posedge cpu_clk) disable iff (rst)
		(stage != 2'd2) |=> $stable(pc))
		else $error("PC changed outside stage 2");

	// Instructions are two bytes wide
	assert property (@(posedge cpu_clk) disable iff (rst) !pc[0])
		else $error("PC is odd");

endmodule

bind chip8_core chip8_core_assertions u_assertions (
	.cpu_clk(cpu_clk),
	.rst(rst),
	.instr_valid(instr_valid),
	.ready(ready),
	.stage(stage),
	.pc(pc)
);

// ==== rtl/chip8_core.sv ====
// CHIP-8 execution core top: sequencer, decoder, ALU, register file and PC/stack
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_core (
	input  logic                     cpu_clk,
	input  logic                     rst,
	input  logic                     instr_valid,
	input  logic [15:0]              instruction,
	output logic                     ready,
	output logic [`CHIP8_ADDR_W-1:0] pc,
	output logic [15:0]              i_reg,
	input  logic [3:0]               dbg_reg_addr,
	output logic [7:0]               dbg_reg_data
);
	import chip8_pkg::*;

	// Sequencer to decoder
	logic [1:0] stage;
	instr_u     instr;

	// Register file ports
	logic [3:0]  rd_addr1, rd_addr2;
	logic [7:0]  rd_data1, rd_data2;
	logic        we1, we2, i_we;
	logic [3:0]  wa1, wa2;
	logic [7:0]  wd1, wd2;
	logic [15:0] i_wd;

	// ALU path
	logic [15:0] alu_a, alu_b, alu_result;
	alu_op_e     alu_op;
	logic        alu_flag;

	// PC and stack controls
	pc_src_e                  pc_src;
	logic [`CHIP8_ADDR_W-1:0] pc_load;
	logic                     push, pop;

	chip8_sequencer u_sequencer (.*);

	chip8_decoder u_decoder (.i_data(i_reg), .pc_now(pc), .*);

	chip8_alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.result(alu_result),
		.flag(alu_flag)
	);

	chip8_reg_file u_reg_file (.i_data(i_reg), .*);

	// Stage encoding is one-hot above idle, so bit 1 marks stage 2
	chip8_pc_stack u_pc_stack (.update(stage[1]), .*);

endmodule

// ==== rtl/chip8_decoder.sv ====
// CHIP-8 decoder: maps the stage and instruction to register, ALU, I, PC and stack controls
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_decoder (
	input  logic [1:0]               stage,
	input  chip8_pkg::instr_u        instr,
	input  logic [7:0]               rd_data1,
	input  logic [7:0]               rd_data2,
	input  logic [15:0]              i_data,
	input  logic [`CHIP8_ADDR_W-1:0] pc_now,
	input  logic [15:0]              alu_result,
	input  logic                     alu_flag,
	output logic [3:0]               rd_addr1,
	output logic [3:0]               rd_addr2,
	output logic                     we1,
	output logic [3:0]               wa1,
	output logic [7:0]               wd1,
	output logic                     we2,
	output logic [3:0]               wa2,
	output logic [7:0]               wd2,
	output logic                     i_we,
	output logic [15:0]              i_wd,
	output logic [15:0]              alu_a,
	output logic [15:0]              alu_b,
	output chip8_pkg::alu_op_e       alu_op,
	output chip8_pkg::pc_src_e       pc_src,
	output logic [`CHIP8_ADDR_W-1:0] pc_load,
	output logic                     push,
	output logic                     pop
);
	import chip8_pkg::*;

	logic [3:0]               op;
	logic [3:0]               x;
	logic [3:0]               y;
	logic [3:0]               n;
	logic [7:0]               kk;
	logic [`CHIP8_ADDR_W-1:0] nnn;
	logic [15:0]              nnn_ext;

	// Field extraction through the three union views
	assign op      = instr.nnn_v.op;
	assign nnn     = instr.nnn_v.nnn;
	assign x       = instr.xkk_v.x;
	assign kk      = instr.xkk_v.kk;
	assign y       = instr.xyn_v.y;
	assign n       = instr.xyn_v.n;
	assign nnn_ext = {{(16 - `CHIP8_ADDR_W){1'b0}}, nnn};

	always_comb begin
		rd_addr1 = 4'h0;
		rd_addr2 = 4'h0;
		// Vx and VF are the usual targets, data defaults to the ALU
		we1      = 1'b0;
		wa1      = x;
		wd1      = alu_result[7:0];
		we2      = 1'b0;
		wa2      = 4'hF;
		wd2      = {7'h00, alu_flag};
		i_we     = 1'b0;
		i_wd     = alu_result;
		alu_a    = {8'h00, rd_data1};
		alu_b    = {8'h00, rd_data2};
		alu_op   = ALU_NOP;
		pc_src   = PC_SRC_NEXT;
		// Load path idles at the current PC
		pc_load  = pc_now;
		push     = 1'b0;
		pop      = 1'b0;

		// Read addresses stay up through both stages
		if (stage != 2'd0) begin
			rd_addr1 = (op == 4'hB) ? 4'h0 : x;
			rd_addr2 = y;
		end

		// Execute and write back
		if (stage == 2'd2) begin
			case (op)
				4'h0: begin
					// RET, everything else in this class is a no-op
					if (instr == 16'h00EE) begin
						pop    = 1'b1;
						pc_src = PC_SRC_STACK;
					end
				end
				4'h1: begin
					pc_src  = PC_SRC_LOAD;
					pc_load = nnn;
				end
				4'h2: begin
					// Stack unit saves the return address
					push    = 1'b1;
					pc_src  = PC_SRC_LOAD;
					pc_load = nnn;
				end
				4'h3: if (rd_data1 == kk) pc_src = PC_SRC_SKIP;
				4'h4: if (rd_data1 != kk) pc_src = PC_SRC_SKIP;
				4'h5: if (n == 4'h0 && rd_data1 == rd_data2) pc_src = PC_SRC_SKIP;
				4'h9: if (n == 4'h0 && rd_data1 != rd_data2) pc_src = PC_SRC_SKIP;
				4'h6: begin
					we1 = 1'b1;
					wd1 = kk;
				end
				4'h7: begin
					// Wraps at 8 bits, VF left alone
					alu_b  = {8'h00, kk};
					alu_op = ALU_ADD;
					we1    = 1'b1;
				end
				4'h8: begin
					case (n)
						4'h0: wd1 = rd_data2;
						4'h1: alu_op = ALU_OR;
						4'h2: alu_op = ALU_AND;
						4'h3: alu_op = ALU_XOR;
						4'h4: alu_op = ALU_ADD;
						4'h5: alu_op = ALU_SUB;
						4'h6: begin
							alu_op = ALU_SHR;
							wd2    = {7'h00, rd_data1[0]};
						end
						4'h7: begin
							// SUBN swaps the operands
							alu_a  = {8'h00, rd_data2};
							alu_b  = {8'h00, rd_data1};
							alu_op = ALU_SUB;
						end
						4'hE: begin
							alu_op = ALU_SHL;
							wd2    = {7'h00, rd_data1[7]};
						end
						default: ;
					endcase
					// VF port written last, so it wins when x is F
					we1 = (n inside {[4'h0:4'h7], 4'hE});
					we2 = (n inside {[4'h4:4'h7], 4'hE});
				end
				4'hA: begin
					i_we = 1'b1;
					i_wd = nnn_ext;
				end
				4'hB: begin
					// V0 plus nnn, truncated to 12 bits
					alu_b   = nnn_ext;
					alu_op  = ALU_ADD;
					pc_src  = PC_SRC_LOAD;
					pc_load = alu_result[`CHIP8_ADDR_W-1:0];
				end
				4'hF: begin
					// ADD I,Vx only, other F-class codes fall through
					if (kk == 8'h1E) begin
						alu_a  = i_data;
						alu_b  = {8'h00, rd_data1};
						alu_op = ALU_ADD;
						i_we   = 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/chip8_sequencer.sv ====
// CHIP-8 sequencer: accepts one instruction and steps it through read and execute stages
`timescale 1ns/1ps

module chip8_sequencer (
	input  logic              cpu_clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  logic [15:0]       instruction,
	output logic              ready,
	output logic [1:0]        stage,
	output chip8_pkg::instr_u instr
);

	// Idle 0, register read 1, execute and write back 2
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			stage <= 2'd0;
		end else begin
			case (stage)
				2'd0: if (instr_valid) stage <= 2'd1;
				2'd1: stage <= 2'd2;
				default: stage <= 2'd0;
			endcase
		end
	end

	// Word held steady for both stages
	always_ff @(posedge cpu_clk) begin
		if (ready && instr_valid) begin
			instr <= instruction;
		end
	end

	// Only idle takes a new word
	assign ready = (stage == 2'd0);

endmodule

// ==== rtl/chip8_pc_stack.sv ====
// CHIP-8 program counter and return stack, updated once per instruction
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_pc_stack (
	input  logic                     cpu_clk,
	input  logic                     rst,
	input  logic                     update,
	input  chip8_pkg::pc_src_e       pc_src,
	input  logic [`CHIP8_ADDR_W-1:0] pc_load,
	input  logic                     push,
	input  logic                     pop,
	output logic [`CHIP8_ADDR_W-1:0] pc
);
	import chip8_pkg::*;

	localparam int SP_W = $clog2(`CHIP8_STACK_DEPTH);

	logic [`CHIP8_ADDR_W-1:0] stack_mem [`CHIP8_STACK_DEPTH];
	logic [SP_W-1:0]          sp;
	logic [`CHIP8_ADDR_W-1:0] pc_plus2;
	logic [`CHIP8_ADDR_W-1:0] pc_next;

	assign pc_plus2 = pc + 2'd2;

	always_comb begin
		case (pc_src)
			PC_SRC_SKIP:  pc_next = pc + 3'd4;
			PC_SRC_LOAD:  pc_next = pc_load;
			// Top entry sits just below the pointer
			PC_SRC_STACK: pc_next = stack_mem[sp - 1'b1];
			default:      pc_next = pc_plus2;
		endcase
	end

	// sp counts entries, wraps both ways
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			pc <= `CHIP8_PC_RESET;
			sp <= '0;
		end else if (update) begin
			pc <= pc_next;
			if (push) sp <= sp + 1'b1;
			else if (pop) sp <= sp - 1'b1;
		end
	end

	// Return address is the word after the CALL
	always_ff @(posedge cpu_clk) begin
		if (update && push) stack_mem[sp] <= pc_plus2;
	end

endmodule

// ==== rtl/chip8_reg_file.sv ====
// CHIP-8 register file: V0 to VF with two read and two write ports, plus the I register
`timescale 1ns/1ps
`include "chip8_settings.svh"

module chip8_reg_file (
	input  logic        cpu_clk,
	input  logic        rst,
	input  logic [3:0]  rd_addr1,
	input  logic [3:0]  rd_addr2,
	output logic [7:0]  rd_data1,
	output logic [7:0]  rd_data2,
	input  logic        we1,
	input  logic [3:0]  wa1,
	input  logic [7:0]  wd1,
	input  logic        we2,
	input  logic [3:0]  wa2,
	input  logic [7:0]  wd2,
	input  logic        i_we,
	input  logic [15:0] i_wd,
	output logic [15:0] i_data,
	input  logic [3:0]  dbg_reg_addr,
	output logic [7:0]  dbg_reg_data
);

	logic [7:0] v_regs [`CHIP8_NUM_REGS];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			for (int r = 0; r < `CHIP8_NUM_REGS; r++) begin
				v_regs[r] <= 8'h00;
			end
			i_data <= 16'h0000;
		end else begin
			if (we1) v_regs[wa1] <= wd1;
			// Second port overrides on a shared address
			if (we2) v_regs[wa2] <= wd2;
			if (i_we) i_data <= i_wd;
		end
	end

	// Asynchronous reads, debug port included
	assign rd_data1     = v_regs[rd_addr1];
	assign rd_data2     = v_regs[rd_addr2];
	assign dbg_reg_data = v_regs[dbg_reg_addr];

endmodule

// ==== rtl/chip8_alu.sv ====
// CHIP-8 ALU for 16-bit add, subtract and logic ops with a byte carry flag and byte shifts
`timescale 1ns/1ps

module chip8_alu (
	input  logic [15:0]        a,
	input  logic [15:0]        b,
	input  chip8_pkg::alu_op_e op,
	output logic [15:0]        result,
	output logic               flag
);
	import chip8_pkg::*;

	// Low byte sum with the VF carry in bit 8
	logic [8:0] sum_lo;

	assign sum_lo = {1'b0, a[7:0]} + {1'b0, b[7:0]};

	always_comb begin
		result = 16'h0000;
		flag   = 1'b0;
		case (op)
			ALU_ADD: begin
				result = a + b;
				flag   = sum_lo[8];
			end
			ALU_SUB: begin
				result = a - b;
				// Not borrow
				flag   = (a[7:0] >= b[7:0]);
			end
			ALU_OR:  result = a | b;
			ALU_AND: result = a & b;
			ALU_XOR: result = a ^ b;
			// Shifted-out bit reaches VF through the decoder
			ALU_SHR: result = {8'h00, 1'b0, a[7:1]};
			ALU_SHL: result = {8'h00, a[6:0], 1'b0};
			default: ;
		endcase
	end

endmodule

// ==== rtl/chip8_pkg.sv ====
// CHIP-8 shared types: ALU function, PC source and the decoded instruction word
`include "chip8_settings.svh"

package chip8_pkg;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_NOP = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_OR  = 3'd3,
		ALU_AND = 3'd4,
		ALU_XOR = 3'd5,
		ALU_SHR = 3'd6,
		ALU_SHL = 3'd7
	} alu_op_e;

	// Next PC selection at the end of stage 2
	typedef enum logic [1:0] {
		PC_SRC_NEXT  = 2'd0,
		PC_SRC_SKIP  = 2'd1,
		PC_SRC_LOAD  = 2'd2,
		PC_SRC_STACK = 2'd3
	} pc_src_e;

	// One 16-bit opcode, read three ways depending on the instruction class
	typedef union packed {
		// Jumps, calls and LD I
		struct packed {
			logic [3:0]               op;
			logic [`CHIP8_ADDR_W-1:0] nnn;
		} nnn_v;
		// Register and byte immediate
		struct packed {
			logic [3:0] op;
			logic [3:0] x;
			logic [7:0] kk;
		} xkk_v;
		// Register pair with subfunction nibble
		struct packed {
			logic [3:0] op;
			logic [3:0] x;
			logic [3:0] y;
			logic [3:0] n;
		} xyn_v;
	} instr_u;

endpackage

// ==== rtl/chip8_settings.svh ====
// CHIP-8 core sizes fixed by the architecture: register count, address width, stack, reset PC
`ifndef CHIP8_SETTINGS_SVH
`define CHIP8_SETTINGS_SVH

// V0 through VF
`define CHIP8_NUM_REGS 16

// 4 KiB address space, so PC and nnn are 12 bits
`define CHIP8_ADDR_W 12

// Return stack entries, wraps when overfilled
`define CHIP8_STACK_DEPTH 16

// Programs are loaded above the interpreter area
`define CHIP8_PC_RESET 12'h200

`endif
